/* usb_pkg.sv */
/*
 * USB full-speed transmit package
 * PIDs, line timing, CRC16 constants and shared enum types
 */
`default_nettype none

package usb_pkg;

	// Line timing
	localparam int BIT_CYCLES  = 4;
	localparam int STUFF_LIMIT = 6;

	localparam int FIFO_DEPTH = 16;

	localparam logic [7:0] SYNC_BYTE = 8'h80;
	localparam logic [7:0] PID_ACK   = 8'hD2;

	// CRC16 as used on USB data packets
	localparam logic [15:0] CRC16_POLY = 16'h8005;
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	function automatic logic [15:0] reflect16(input logic [15:0] v);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[i] = v[15 - i];
		end
		return r;
	endfunction

	// LSB-first shifting needs the bit-reversed polynomial
	localparam logic [15:0] CRC16_POLY_REFL = reflect16(CRC16_POLY);

	typedef enum logic [1:0] {SYM_J, SYM_K, SYM_SE0} line_sym_t;

	typedef enum logic {DATA_PKT, ACK_PKT} cmd_kind_t;

endpackage

`default_nettype wire

/* usb_tx_fifo.sv */
/*
 * Transmit byte FIFO
 * Four-phase write port, single-cycle pop strobe, head shown combinationally
 */
`default_nettype none

module usb_tx_fifo (
	input wire clk,
	input wire n_rst,
	input wire [7:0] wr_data,
	input wire wr_req,
	input wire rd_en,
	output logic wr_ack,
	output logic [7:0] rd_data,
	output logic empty,
	output logic full
);
	import usb_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [7:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic push;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// One store per request and none while full
	assign push = wr_req && !wr_ack && !full;

	assign empty = (count == '0);
	assign full = (count == (AW+1)'(FIFO_DEPTH));
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ack <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
				wr_ack <= 1'b1;
			end else if (!wr_req) begin
				wr_ack <= 1'b0;
			end
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !push)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!n_rst) rd_en |-> !empty)
		else $error("pop from empty FIFO");

	// Pointers meet only when the FIFO is empty or full
	assert property (@(posedge clk) disable iff (!n_rst)
		(wr_ptr == rd_ptr) == (empty || full))
		else $error("FIFO pointers disagree with fill count");

endmodule

`default_nettype wire

/* usb_crc16.sv */
/*
 * CRC16 accumulator, one byte per cycle, LSB first
 * Output is the complemented remainder, ready to send
 */
`default_nettype none

module usb_crc16 (
	input wire clk,
	input wire n_rst,
	input wire crc_clear,
	input wire crc_update,
	input wire [7:0] byte_in,
	output logic [15:0] crc_out
);
	import usb_pkg::*;

	logic [15:0] rem;

	function automatic logic [15:0] fold_byte(input logic [15:0] r_in, input logic [7:0] d);
		logic [15:0] r;
		r = r_in;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ CRC16_POLY_REFL;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			rem <= CRC16_INIT;
		else if (crc_clear)
			rem <= CRC16_INIT;
		else if (crc_update)
			rem <= fold_byte(rem, byte_in);
	end

	assign crc_out = ~rem;

endmodule

`default_nettype wire

/* usb_tx_serializer.sv */
/*
 * Line serializer: bit timer, LSB-first shifter, bit stuffing, NRZI and EOP
 * Drives dp/dm one symbol every BIT_CYCLES clocks
 */
`default_nettype none

module usb_tx_serializer (
	input wire clk,
	input wire n_rst,
	input wire load,
	input wire [7:0] byte_in,
	input wire send_eop,
	output logic byte_done,
	output logic eop_done,
	output logic dp,
	output logic dm
);
	import usb_pkg::*;

	localparam int TW = $clog2(BIT_CYCLES);
	localparam int OW = $clog2(STUFF_LIMIT + 1);

	typedef enum logic [1:0] {S_IDLE, S_BITS, S_EOP} ser_state_t;

	ser_state_t state;
	logic [TW-1:0] tick;
	logic [7:0] shreg;
	logic [2:0] bit_idx;
	logic [OW-1:0] ones;
	logic [1:0] eop_cnt;
	line_sym_t sym;

	logic boundary;
	logic stuff_due;
	logic byte_end;
	logic ready;

	function automatic line_sym_t toggle(input line_sym_t s);
		return (s == SYM_K) ? SYM_J : SYM_K;
	endfunction

	assign boundary = (tick == TW'(BIT_CYCLES - 1));
	// Six ones on the line, a stuffed zero goes next
	assign stuff_due = (ones == OW'(STUFF_LIMIT));
	assign byte_end = (state == S_BITS) && !stuff_due && (bit_idx == 3'd7);
	assign ready = (state == S_IDLE) || (byte_end && boundary);

	// One cycle early so the next load lands on the symbol boundary
	assign byte_done = byte_end && (tick == TW'(BIT_CYCLES - 2));
	assign eop_done = (state == S_EOP) && boundary && (eop_cnt == 2'd2);

	assign dp = (sym == SYM_J);
	assign dm = (sym == SYM_K);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= S_IDLE;
			tick <= '0;
			shreg <= '0;
			bit_idx <= '0;
			ones <= '0;
			eop_cnt <= '0;
			sym <= SYM_J;
		end else begin
			if (state == S_IDLE || boundary)
				tick <= '0;
			else
				tick <= tick + 1'b1;

			if (ready && load) begin
				state <= S_BITS;
				shreg <= byte_in;
				bit_idx <= '0;
				sym <= byte_in[0] ? sym : toggle(sym);
				ones <= byte_in[0] ? ones + 1'b1 : '0;
			end else if (ready && send_eop) begin
				state <= S_EOP;
				eop_cnt <= '0;
				sym <= SYM_SE0;
			end else if (state == S_BITS && boundary) begin
				if (stuff_due) begin
					sym <= toggle(sym);
					ones <= '0;
				end else if (bit_idx != 3'd7) begin
					shreg <= shreg >> 1;
					bit_idx <= bit_idx + 1'b1;
					sym <= shreg[1] ? sym : toggle(sym);
					ones <= shreg[1] ? ones + 1'b1 : '0;
				end else begin
					// Nothing queued, hold the line
					state <= S_IDLE;
				end
			end else if (state == S_EOP && boundary) begin
				eop_cnt <= eop_cnt + 1'b1;
				if (eop_cnt == 2'd1) begin
					sym <= SYM_J;
					ones <= '0;
				end else if (eop_cnt == 2'd2) begin
					state <= S_IDLE;
				end
			end
		end
	end

	// Commands only when idle or exactly at the end of a byte
	assert property (@(posedge clk) disable iff (!n_rst)
		(load || send_eop) |-> (ready && !(load && send_eop)))
		else $error("serializer command while symbol stream in progress");

endmodule

`default_nettype wire

/* usb_tx_controller.sv */
/*
 * Transmit controller FSM
 * Sequences SYNC, PID, payload, CRC16 and EOP, or SYNC, ACK and EOP
 */
`default_nettype none

module usb_tx_controller (
	input wire clk,
	input wire n_rst,
	input wire start,
	input wire usb_pkg::cmd_kind_t kind,
	input wire [7:0] fifo_data,
	input wire fifo_empty,
	input wire [15:0] crc_out,
	input wire byte_done,
	input wire eop_done,
	output logic fifo_rd,
	output logic crc_clear,
	output logic crc_update,
	output logic ser_load,
	output logic [7:0] ser_byte,
	output logic send_eop,
	output logic done,
	output logic busy
);
	import usb_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		SYNC_TX,
		PID_LOAD,
		PID_TX,
		DATA_LOAD,
		DATA_TX,
		CRC_LO_LOAD,
		CRC_LO_TX,
		CRC_HI_LOAD,
		CRC_HI_TX,
		ACK_LOAD,
		ACK_TX,
		EOP_SEND,
		EOP_WAIT,
		DONE
	} state_t;

	state_t state;
	state_t next_state;
	cmd_kind_t kind_q;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
			kind_q <= DATA_PKT;
		end else begin
			state <= next_state;
			if (start && state == IDLE)
				kind_q <= kind;
		end
	end

	always_comb begin
		next_state = state;
		fifo_rd = 1'b0;
		crc_clear = 1'b0;
		crc_update = 1'b0;
		ser_load = 1'b0;
		ser_byte = '0;
		send_eop = 1'b0;
		done = 1'b0;

		unique case (state)
			IDLE: begin
				crc_clear = 1'b1;
				if (start) begin
					ser_load = 1'b1;
					ser_byte = SYNC_BYTE;
					next_state = SYNC_TX;
				end
			end
			SYNC_TX: begin
				if (byte_done)
					next_state = (kind_q == ACK_PKT) ? ACK_LOAD : PID_LOAD;
			end
			// PID comes from the FIFO but stays out of the CRC
			PID_LOAD: begin
				fifo_rd = 1'b1;
				ser_load = 1'b1;
				ser_byte = fifo_data;
				next_state = PID_TX;
			end
			PID_TX, DATA_TX: begin
				if (byte_done)
					next_state = fifo_empty ? CRC_LO_LOAD : DATA_LOAD;
			end
			DATA_LOAD: begin
				fifo_rd = 1'b1;
				crc_update = 1'b1;
				ser_load = 1'b1;
				ser_byte = fifo_data;
				next_state = DATA_TX;
			end
			CRC_LO_LOAD: begin
				ser_load = 1'b1;
				ser_byte = crc_out[7:0];
				next_state = CRC_LO_TX;
			end
			CRC_LO_TX: begin
				if (byte_done)
					next_state = CRC_HI_LOAD;
			end
			CRC_HI_LOAD: begin
				ser_load = 1'b1;
				ser_byte = crc_out[15:8];
				next_state = CRC_HI_TX;
			end
			ACK_LOAD: begin
				ser_load = 1'b1;
				ser_byte = PID_ACK;
				next_state = ACK_TX;
			end
			CRC_HI_TX, ACK_TX: begin
				if (byte_done)
					next_state = EOP_SEND;
			end
			EOP_SEND: begin
				send_eop = 1'b1;
				next_state = EOP_WAIT;
			end
			EOP_WAIT: begin
				if (eop_done)
					next_state = DONE;
			end
			DONE: begin
				done = 1'b1;
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* usb_tx.sv */
/*
 * USB full-speed transmit engine top
 * FIFO, CRC16, controller and line serializer with command handshake
 */
`default_nettype none

module usb_tx (
	input wire clk,
	input wire n_rst,
	input wire [7:0] wr_data,
	input wire wr_req,
	output logic wr_ack,
	input wire usb_pkg::cmd_kind_t cmd_kind,
	input wire cmd_req,
	output logic cmd_ack,
	output logic busy,
	output logic dp,
	output logic dm
);
	logic [7:0] fifo_data;
	logic fifo_empty;
	logic fifo_rd;
	logic crc_clear;
	logic crc_update;
	logic [15:0] crc_out;
	logic ser_load;
	logic [7:0] ser_byte;
	logic send_eop;
	logic byte_done;
	logic eop_done;
	logic done;
	logic cmd_req_q;
	logic start;

	// Rising request edge, only when idle and the last ack has dropped
	assign start = cmd_req && !cmd_req_q && !busy && !cmd_ack;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			cmd_req_q <= 1'b0;
			cmd_ack <= 1'b0;
		end else begin
			cmd_req_q <= cmd_req;
			if (done)
				cmd_ack <= 1'b1;
			else if (!cmd_req)
				cmd_ack <= 1'b0;
		end
	end

	usb_tx_fifo u_fifo (
		.clk(clk), .n_rst(n_rst),
		.wr_data(wr_data), .wr_req(wr_req), .wr_ack(wr_ack),
		.rd_en(fifo_rd), .rd_data(fifo_data), .empty(fifo_empty), .full()
	);

	usb_crc16 u_crc (
		.clk(clk), .n_rst(n_rst),
		.crc_clear(crc_clear), .crc_update(crc_update),
		.byte_in(fifo_data), .crc_out(crc_out)
	);

	usb_tx_controller u_ctrl (
		.clk(clk), .n_rst(n_rst), .start(start), .kind(cmd_kind),
		.fifo_data(fifo_data), .fifo_empty(fifo_empty), .crc_out(crc_out),
		.byte_done(byte_done), .eop_done(eop_done),
		.fifo_rd(fifo_rd), .crc_clear(crc_clear), .crc_update(crc_update),
		.ser_load(ser_load), .ser_byte(ser_byte), .send_eop(send_eop),
		.done(done), .busy(busy)
	);

	usb_tx_serializer u_ser (
		.clk(clk), .n_rst(n_rst),
		.load(ser_load), .byte_in(ser_byte), .send_eop(send_eop),
		.byte_done(byte_done), .eop_done(eop_done), .dp(dp), .dm(dm)
	);

endmodule

`default_nettype wire

/* tb_usb_tx.sv */
/*
 * Testbench for the USB full-speed transmit engine
 * LCG packets, NRZI line decoder and a byte-level packet model
 */
`default_nettype none

module tb_usb_tx;
	import usb_pkg::*;

	localparam int NUM_PKTS = 24;

	logic clk;
	logic n_rst;
	logic [7:0] wr_data;
	logic wr_req;
	cmd_kind_t cmd_kind;
	logic cmd_req;
	logic wr_ack;
	logic cmd_ack;
	logic busy;
	logic dp;
	logic dm;

	logic [31:0] lcg_state;
	logic [7:0] exp_bytes[$];
	logic [7:0] got_bytes[$];
	logic [7:0] payload[$];

	usb_tx dut (
		.clk(clk), .n_rst(n_rst),
		.wr_data(wr_data), .wr_req(wr_req), .wr_ack(wr_ack),
		.cmd_kind(cmd_kind), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
		.busy(busy), .dp(dp), .dm(dm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Half the bytes are all ones to provoke stuffing
	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[31] ? 8'hFF : r[23:16];
	endfunction

	// CRC16 over the payload in transmit bit order, MSB-first register
	function automatic logic [15:0] expected_crc();
		logic [15:0] c;
		logic [15:0] t;
		logic fb;
		c = CRC16_INIT;
		for (int i = 0; i < payload.size(); i++) begin
			for (int b = 0; b < 8; b++) begin
				fb = c[15] ^ payload[i][b];
				c = {c[14:0], 1'b0};
				if (fb)
					c = c ^ CRC16_POLY;
			end
		end
		// Top register bit goes out first, complemented
		for (int i = 0; i < 16; i++)
			t[i] = ~c[15 - i];
		return t;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got 8'h%02h expected 8'h%02h",
				$time, name, got, exp));
	endtask

	task automatic check_sym(input string name, input line_sym_t got, input line_sym_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %s expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic sample_line(output line_sym_t s);
		if (dp === 1'b1 && dm === 1'b0)
			s = SYM_J;
		else if (dp === 1'b0 && dm === 1'b1)
			s = SYM_K;
		else if (dp === 1'b0 && dm === 1'b0)
			s = SYM_SE0;
		else
			abort_run($sformatf("illegal line state dp=%b dm=%b at %0t", dp, dm, $time));
	endtask

	// Entered on the first falling edge of a symbol, leaves on the first one of the next
	task automatic read_symbol(output line_sym_t s);
		line_sym_t now;
		sample_line(s);
		for (int c = 0; c < BIT_CYCLES; c++) begin
			if (c > 0) begin
				sample_line(now);
				check_sym("dp/dm within symbol", now, s);
			end
			check_bit("busy", busy, 1'b1);
			check_bit("cmd_ack", cmd_ack, 1'b0);
			@(negedge clk);
		end
	endtask

	task automatic decode_packet();
		line_sym_t s;
		line_sym_t prev;
		logic [7:0] cur;
		logic bit_val;
		int nbits;
		int ones;
		int n;
		got_bytes.delete();
		s = SYM_J;
		n = 0;
		while (s != SYM_K) begin
			@(negedge clk);
			sample_line(s);
			n++;
			if (n > 20)
				abort_run("no K symbol on the line after the command");
		end
		prev = SYM_J;
		cur = '0;
		nbits = 0;
		ones = 0;
		n = 0;
		read_symbol(s);
		while (s != SYM_SE0) begin
			n++;
			if (n > 400)
				abort_run("packet never reached SE0");
			// NRZI, no transition means a one
			bit_val = (s == prev);
			prev = s;
			if (ones == STUFF_LIMIT) begin
				check_bit("stuffed bit", bit_val, 1'b0);
				ones = 0;
			end else begin
				cur = {bit_val, cur[7:1]};
				nbits++;
				ones = bit_val ? ones + 1 : 0;
				if (nbits % 8 == 0)
					got_bytes.push_back(cur);
			end
			read_symbol(s);
		end
		if (nbits % 8 != 0)
			abort_run($sformatf("packet ended after %0d bits, not a whole byte", nbits));
		read_symbol(s);
		check_sym("second EOP symbol", s, SYM_SE0);
		read_symbol(s);
		check_sym("symbol after EOP", s, SYM_J);
	endtask

	task automatic finish_write(input int limit);
		int n;
		n = 0;
		while (wr_ack !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > limit)
				abort_run("wr_ack never rose for a FIFO write");
		end
		wr_req = 1'b0;
		n = 0;
		while (wr_ack !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 10)
				abort_run("wr_ack did not fall after wr_req dropped");
		end
	endtask

	task automatic write_byte(input logic [7:0] b);
		wr_data = b;
		wr_req = 1'b1;
		finish_write(10);
	endtask

	task automatic load_data_packet(input int len);
		logic [31:0] r;
		logic [7:0] b;
		r = lcg_next();
		b = r[20] ? 8'hC3 : 8'h4B;
		exp_bytes.delete();
		payload.delete();
		exp_bytes.push_back(SYNC_BYTE);
		exp_bytes.push_back(b);
		write_byte(b);
		for (int i = 0; i < len; i++) begin
			b = random_byte();
			payload.push_back(b);
			exp_bytes.push_back(b);
			write_byte(b);
		end
	endtask

	task automatic append_crc();
		logic [15:0] t;
		t = expected_crc();
		exp_bytes.push_back(t[7:0]);
		exp_bytes.push_back(t[15:8]);
	endtask

	task automatic send_and_check(input cmd_kind_t kind);
		int n;
		cmd_kind = kind;
		cmd_req = 1'b1;
		decode_packet();
		for (int i = 0; i < exp_bytes.size(); i++) begin
			if (i >= got_bytes.size())
				abort_run($sformatf("packet had %0d bytes, expected %0d",
					got_bytes.size(), exp_bytes.size()));
			check_byte($sformatf("decoded byte %0d", i), got_bytes[i], exp_bytes[i]);
		end
		if (got_bytes.size() > exp_bytes.size())
			abort_run($sformatf("packet had %0d bytes, expected %0d",
				got_bytes.size(), exp_bytes.size()));
		n = 0;
		while (cmd_ack !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 10)
				abort_run("cmd_ack did not rise after EOP");
		end
		check_bit("busy", busy, 1'b0);
		cmd_req = 1'b0;
		n = 0;
		while (cmd_ack !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 10)
				abort_run("cmd_ack did not fall after cmd_req dropped");
		end
	endtask

	initial begin
		line_sym_t s;
		logic [31:0] r;
		logic [7:0] extra;
		lcg_state = 32'h3ea8_d28c;
		n_rst = 1'b0;
		wr_data = '0;
		wr_req = 1'b0;
		cmd_kind = DATA_PKT;
		cmd_req = 1'b0;
		repeat (5) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		sample_line(s);
		check_sym("dp/dm after reset", s, SYM_J);
		check_bit("busy", busy, 1'b0);
		check_bit("wr_ack", wr_ack, 1'b0);
		check_bit("cmd_ack", cmd_ack, 1'b0);

		for (int p = 0; p < NUM_PKTS; p++) begin
			r = lcg_next();
			if (r[27:26] == 2'b00) begin
				exp_bytes.delete();
				exp_bytes.push_back(SYNC_BYTE);
				exp_bytes.push_back(PID_ACK);
				send_and_check(ACK_PKT);
			end else begin
				load_data_packet(1 + int'(r[19:16]) % 12);
				append_crc();
				send_and_check(DATA_PKT);
			end
		end

		// Fill the FIFO, then one more write must wait for the first pop
		load_data_packet(FIFO_DEPTH - 1);
		extra = random_byte();
		payload.push_back(extra);
		exp_bytes.push_back(extra);
		append_crc();
		wr_data = extra;
		wr_req = 1'b1;
		repeat (8) begin
			@(negedge clk);
			check_bit("wr_ack while FIFO full", wr_ack, 1'b0);
		end
		fork
			finish_write(200);
			send_and_check(DATA_PKT);
		join

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
usb_pkg.sv
usb_tx_fifo.sv
usb_crc16.sv
usb_tx_serializer.sv
usb_tx_controller.sv
usb_tx.sv
tb_usb_tx.sv

/* Bender.yml */
package:
  name: usb_tx

sources:
  - usb_pkg.sv
  - usb_tx_fifo.sv
  - usb_crc16.sv
  - usb_tx_serializer.sv
  - usb_tx_controller.sv
  - usb_tx.sv
  - target: simulation
    files:
      - tb_usb_tx.sv
